/* files.f */
+incdir+rtl
rtl/stream_pkg.sv
rtl/spi_pkg.sv
rtl/spi_sclk_gen.sv
rtl/spi_shifter.sv
rtl/spi_frame_ctrl.sv
rtl/spi_master_top.sv
verification/tb_clock_gen.sv
verification/spi_echo_slave.sv
verification/tb_spi_master.sv

/* rtl/spi_config.svh */
`ifndef SPI_CONFIG_SVH
`define SPI_CONFIG_SVH

// --------------------
// Word format
// --------------------

// Bits per SPI word, also the stream data width
`define SPI_DATA_WIDTH 8

// Number of slaves, one chip select each
`define SPI_SLAVE_NUM 4

// --------------------
// Run-time counter widths
// --------------------

// System clocks per SPI clock period
`define SPI_DIV_WIDTH 16

// Idle cycles after a frame
`define SPI_GAP_WIDTH 16

`endif

/* rtl/spi_frame_ctrl.sv */
`timescale 1ns/100ps

`include "spi_config.svh"

module spi_frame_ctrl (
    input  logic                       clk_i,
    input  logic                       rstn_i,
    input  spi_pkg::spi_cfg_t          cfg_i,
    input  logic                       in_valid_i,
    input  stream_pkg::stream_beat_t   in_beat_i,
    output logic                       in_ready_o,
    output logic                       out_valid_o,
    output stream_pkg::stream_beat_t   out_beat_o,
    input  logic                       out_ready_i,
    input  logic                       word_done_i,
    input  logic [`SPI_DATA_WIDTH-1:0] rx_word_i,
    output logic                       start_o,
    output logic [`SPI_DATA_WIDTH-1:0] tx_word_o,
    output logic [`SPI_SLAVE_NUM-1:0]  cs_n_o
);

    localparam int GAP_W = `SPI_GAP_WIDTH;
    localparam int SN    = `SPI_SLAVE_NUM;

    spi_pkg::ctrl_state_e state;
    logic                 last_q;
    logic                 cs_open;
    logic [GAP_W-1:0]     gap_cnt;
    logic                 gap_done;
    logic                 accept;
    logic                 out_take;

    // No new word while an output beat is still unread
    assign in_ready_o = (state == spi_pkg::IDLE) && !out_valid_o;
    assign accept     = in_valid_i && in_ready_o;
    assign out_take   = out_valid_o && out_ready_i;
    assign start_o    = accept;
    assign tx_word_o  = in_beat_i.data;
    assign gap_done   = (gap_cnt == cfg_i.gap_time - GAP_W'(1));

    // --------------------
    // Frame FSM
    // --------------------

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state   <= spi_pkg::IDLE;
            last_q  <= 1'b0;
            cs_open <= 1'b0;
        end else begin
            case (state)
                spi_pkg::IDLE: begin
                    if (accept) begin
                        state   <= spi_pkg::SHIFT;
                        last_q  <= in_beat_i.last;
                        cs_open <= 1'b1;
                    end
                end
                spi_pkg::SHIFT: begin
                    if (word_done_i) begin
                        if (last_q) begin
                            state   <= spi_pkg::GAP;
                            cs_open <= 1'b0;
                        end else begin
                            state <= spi_pkg::IDLE;
                        end
                    end
                end
                spi_pkg::GAP: begin
                    if (gap_done) begin
                        state <= spi_pkg::IDLE;
                    end
                end
                default: state <= spi_pkg::IDLE;
            endcase
        end
    end

    // Counts idle cycles while in the gap state
    always_ff @(posedge clk_i) begin
        if (!rstn_i || (state != spi_pkg::GAP)) begin
            gap_cnt <= '0;
        end else begin
            gap_cnt <= gap_cnt + GAP_W'(1);
        end
    end

    // --------------------
    // Output beat
    // --------------------

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            out_valid_o <= 1'b0;
        end else if (word_done_i) begin
            out_valid_o <= 1'b1;
        end else if (out_take) begin
            out_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (word_done_i) begin
            out_beat_o.data <= rx_word_i;
            out_beat_o.last <= last_q;
        end
    end

    // One-hot active-low select of the addressed slave
    assign cs_n_o = cs_open ? ~(SN'(1) << cfg_i.addr) : '1;

endmodule

/* rtl/spi_master_top.sv */
`timescale 1ns/100ps

`include "spi_config.svh"

module spi_master_top (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  spi_pkg::spi_cfg_t        cfg_i,
    input  logic                     in_valid_i,
    input  stream_pkg::stream_beat_t in_beat_i,
    output logic                     in_ready_o,
    output logic                     out_valid_o,
    output stream_pkg::stream_beat_t out_beat_o,
    input  logic                     out_ready_i,
    output spi_pkg::spi_bus_t        spi_o,
    input  logic                     spi_miso_i
);

    logic                       start;
    logic [`SPI_DATA_WIDTH-1:0] tx_word;
    logic [`SPI_DATA_WIDTH-1:0] rx_word;
    logic                       word_done;
    logic                       lead_edge;
    logic                       trail_edge;
    logic                       sclk;
    logic                       mosi;
    logic [`SPI_SLAVE_NUM-1:0]  cs_n;

    spi_frame_ctrl frame_ctrl_i (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .cfg_i       (cfg_i),
        .in_valid_i  (in_valid_i),
        .in_beat_i   (in_beat_i),
        .in_ready_o  (in_ready_o),
        .out_valid_o (out_valid_o),
        .out_beat_o  (out_beat_o),
        .out_ready_i (out_ready_i),
        .word_done_i (word_done),
        .rx_word_i   (rx_word),
        .start_o     (start),
        .tx_word_o   (tx_word),
        .cs_n_o      (cs_n)
    );

    spi_sclk_gen sclk_gen_i (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .start_i      (start),
        .cfg_i        (cfg_i),
        .sclk_o       (sclk),
        .lead_edge_o  (lead_edge),
        .trail_edge_o (trail_edge),
        .done_o       (word_done)
    );

    spi_shifter shifter_i (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .start_i      (start),
        .tx_word_i    (tx_word),
        .cpha_i       (cfg_i.cpha),
        .lead_edge_i  (lead_edge),
        .trail_edge_i (trail_edge),
        .miso_i       (spi_miso_i),
        .mosi_o       (mosi),
        .rx_word_o    (rx_word)
    );

    // Bus pins gathered into one struct
    assign spi_o.sclk = sclk;
    assign spi_o.mosi = mosi;
    assign spi_o.cs_n = cs_n;

endmodule

/* rtl/spi_pkg.sv */
`include "spi_config.svh"

package spi_pkg;

    // Slave address width, at least one bit
    localparam int ADDR_WIDTH = (`SPI_SLAVE_NUM > 1) ? $clog2(`SPI_SLAVE_NUM) : 1;

    // --------------------
    // Bus and settings
    // --------------------

    // Pins driven by the master
    typedef struct packed {
        logic                      sclk;
        logic                      mosi;
        logic [`SPI_SLAVE_NUM-1:0] cs_n;
    } spi_bus_t;

    // Run-time mode, timing and slave select
    typedef struct packed {
        logic                      cpol;
        logic                      cpha;
        logic [`SPI_DIV_WIDTH-1:0] clk_div;
        logic [`SPI_GAP_WIDTH-1:0] gap_time;
        logic [ADDR_WIDTH-1:0]     addr;
    } spi_cfg_t;

    // Frame controller states
    typedef enum logic [1:0] {
        IDLE  = 2'b00,
        SHIFT = 2'b01,
        GAP   = 2'b10
    } ctrl_state_e;

endpackage

/* rtl/spi_sclk_gen.sv */
`timescale 1ns/100ps

`include "spi_config.svh"

module spi_sclk_gen (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic              start_i,
    input  spi_pkg::spi_cfg_t cfg_i,
    output logic              sclk_o,
    output logic              lead_edge_o,
    output logic              trail_edge_o,
    output logic              done_o
);

    localparam int DIV_W    = `SPI_DIV_WIDTH;
    localparam int EDGE_NUM = 2 * `SPI_DATA_WIDTH;
    localparam int EDGE_W   = $clog2(EDGE_NUM);

    logic              active;
    logic [DIV_W-1:0]  clk_cnt;
    logic [EDGE_W-1:0] edge_cnt;
    logic              half_hit;
    logic              full_hit;
    logic              last_edge;

    // Lead edge at half period, trail edge at full period
    assign half_hit  = (clk_cnt == (cfg_i.clk_div >> 1) - DIV_W'(1));
    assign full_hit  = (clk_cnt == cfg_i.clk_div - DIV_W'(1));
    assign last_edge = (edge_cnt == EDGE_W'(EDGE_NUM - 1));

    // --------------------
    // Divider counter
    // --------------------

    // Loaded with one so the first edge lands half a period after start
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            clk_cnt <= '0;
        end else if (start_i) begin
            clk_cnt <= DIV_W'(1);
        end else if (active) begin
            if (full_hit) begin
                clk_cnt <= '0;
            end else begin
                clk_cnt <= clk_cnt + DIV_W'(1);
            end
        end
    end

    // --------------------
    // Edges and SPI clock
    // --------------------

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            active       <= 1'b0;
            edge_cnt     <= '0;
            sclk_o       <= cfg_i.cpol;
            lead_edge_o  <= 1'b0;
            trail_edge_o <= 1'b0;
            done_o       <= 1'b0;
        end else begin
            lead_edge_o  <= 1'b0;
            trail_edge_o <= 1'b0;
            // Only the final trail edge is seen with active already low
            done_o       <= trail_edge_o && !active;
            if (start_i) begin
                active   <= 1'b1;
                edge_cnt <= '0;
            end else if (active && (half_hit || full_hit)) begin
                sclk_o       <= ~sclk_o;
                edge_cnt     <= edge_cnt + EDGE_W'(1);
                lead_edge_o  <= half_hit;
                trail_edge_o <= full_hit;
                if (last_edge) begin
                    active <= 1'b0;
                end
            end else if (!active) begin
                // Idle level follows polarity
                sclk_o <= cfg_i.cpol;
            end
        end
    end

endmodule

/* rtl/spi_shifter.sv */
`timescale 1ns/100ps

`include "spi_config.svh"

module spi_shifter (
    input  logic                       clk_i,
    input  logic                       rstn_i,
    input  logic                       start_i,
    input  logic [`SPI_DATA_WIDTH-1:0] tx_word_i,
    input  logic                       cpha_i,
    input  logic                       lead_edge_i,
    input  logic                       trail_edge_i,
    input  logic                       miso_i,
    output logic                       mosi_o,
    output logic [`SPI_DATA_WIDTH-1:0] rx_word_o
);

    localparam int W = `SPI_DATA_WIDTH;

    logic [W-1:0] tx_sr;
    logic         shift_edge;
    logic         sample_edge;

    // Mode 0/2 drive on trail and sample on lead, mode 1/3 the other way
    assign shift_edge  = cpha_i ? lead_edge_i : trail_edge_i;
    assign sample_edge = cpha_i ? trail_edge_i : lead_edge_i;

    // --------------------
    // Transmit side
    // --------------------

    // With cpha low the MSB leaves at start, so load the word pre-shifted
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            if (cpha_i) begin
                tx_sr <= tx_word_i;
            end else begin
                tx_sr <= {tx_word_i[W-2:0], 1'b0};
            end
        end else if (shift_edge) begin
            tx_sr <= {tx_sr[W-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            mosi_o <= 1'b0;
        end else if (start_i && !cpha_i) begin
            mosi_o <= tx_word_i[W-1];
        end else if (shift_edge) begin
            mosi_o <= tx_sr[W-1];
        end
    end

    // --------------------
    // Receive side
    // --------------------

    // MSB first, complete by the word done strobe
    always_ff @(posedge clk_i) begin
        if (sample_edge) begin
            rx_word_o <= {rx_word_o[W-2:0], miso_i};
        end
    end

endmodule

/* rtl/stream_pkg.sv */
`include "spi_config.svh"

package stream_pkg;

    // Stream word width follows the SPI word
    localparam int STREAM_DATA_WIDTH = `SPI_DATA_WIDTH;

    // --------------------
    // Stream beat
    // --------------------

    // One beat of the byte stream, handshake travels beside it
    typedef struct packed {
        logic [STREAM_DATA_WIDTH-1:0] data;
        logic                         last;
    } stream_beat_t;

endpackage

/* run_sim.sh */
#!/bin/sh
# Build and run with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f files.f --top-module tb_spi_master \
    -o tb_spi_master > build.log 2>&1 \
    && ./obj_dir/tb_spi_master > sim.log 2>&1 \
    || echo "TESTS FAILED" >> sim.log
cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1 || exit 0

/* verification/spi_echo_slave.sv */
`timescale 1ns/100ps

`include "spi_config.svh"

module spi_echo_slave #(
    parameter logic [`SPI_DATA_WIDTH-1:0] FIRST_WORD = '0
) (
    input  logic cpol_i,
    input  logic cpha_i,
    input  logic sclk_i,
    input  logic mosi_i,
    input  logic cs_n_i,
    output logic miso_o
);

    localparam int W = `SPI_DATA_WIDTH;

    logic [W-1:0] tx_word;
    logic [W-1:0] rx_sr;
    logic [W-1:0] next_word;
    logic         lead;
    int           drive_cnt;
    int           sample_cnt;

    initial begin
        miso_o     = 1'b0;
        tx_word    = FIRST_WORD;
        rx_sr      = '0;
        next_word  = FIRST_WORD;
        drive_cnt  = 0;
        sample_cnt = 0;
    end

    // New frame starts with the fixed first word
    always @(negedge cs_n_i) begin
        tx_word    = FIRST_WORD;
        rx_sr      = '0;
        drive_cnt  = 0;
        sample_cnt = 0;
        miso_o     = FIRST_WORD[W-1];
    end

    always @(sclk_i) begin
        if (!cs_n_i) begin
            lead = (sclk_i != cpol_i);
            if (lead != cpha_i) begin
                // Sample edge
                rx_sr = {rx_sr[W-2:0], mosi_i};
                sample_cnt++;
                if (sample_cnt == W) begin
                    sample_cnt = 0;
                    next_word  = rx_sr;
                    if (cpha_i) begin
                        tx_word   = rx_sr;
                        drive_cnt = 0;
                    end
                end
            end else if (cpha_i) begin
                miso_o = tx_word[W-1-drive_cnt];
                drive_cnt++;
            end else begin
                // cpha 0, next bit after each trail edge
                drive_cnt++;
                if (drive_cnt == W) begin
                    drive_cnt = 0;
                    tx_word   = next_word;
                end
                miso_o = tx_word[W-1-drive_cnt];
            end
        end
    end

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 2
) (
    output logic clk_o,
    output logic rstn_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Reset released on a rising edge
    initial begin
        rstn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rstn_o <= 1'b1;
    end

endmodule

/* verification/tb_spi_master.sv */
`timescale 1ns/100ps

`include "spi_config.svh"

module tb_spi_master;

    localparam int           W          = `SPI_DATA_WIDTH;
    localparam int           SN         = `SPI_SLAVE_NUM;
    localparam int           AW         = spi_pkg::ADDR_WIDTH;
    localparam logic [W-1:0] FIRST_WORD = 8'h5A;
    localparam int           FRAMES     = 3;
    localparam int           MAX_WORDS  = 4 * FRAMES * 4;
    localparam int           MAX_DIV    = 10;
    localparam int           MAX_GAP    = 8;
    localparam int           PERIOD     = 40;
    localparam int           WATCHDOG_NS = MAX_WORDS * (W * MAX_DIV + MAX_GAP + 20) * 2 * PERIOD;

    logic                     clk;
    logic                     rstn;
    spi_pkg::spi_cfg_t        cfg;
    logic                     in_valid;
    logic                     in_ready;
    stream_pkg::stream_beat_t in_beat;
    logic                     out_valid;
    logic                     out_ready;
    stream_pkg::stream_beat_t out_beat;
    spi_pkg::spi_bus_t        spi;
    logic                     miso;

    int          seed;
    logic [31:0] rnd;
    string       test_name;
    int          errors;
    int          test_start_errors;
    int          tests_run;
    int          tests_failed;
    int          nwords;

    // Reference model state
    stream_pkg::stream_beat_t exp_q[$];
    stream_pkg::stream_beat_t exp_head;
    logic                     exp_missing;
    logic [W-1:0]             prev_data;
    logic                     first_word;

    logic                      rstn_q;
    logic                      cs_high;
    logic                      cs_high_q;
    logic [`SPI_GAP_WIDTH-1:0] gap_age;
    logic [`SPI_GAP_WIDTH-1:0] gap_age_q;
    logic [`SPI_GAP_WIDTH-1:0] gap_len;
    logic [`SPI_GAP_WIDTH-1:0] gap_len_q;

    tb_clock_gen #(.PERIOD_NS(PERIOD), .RESET_CYCLES(2)) clock_gen_i (
        .clk_o  (clk),
        .rstn_o (rstn)
    );

    spi_master_top dut_i (
        .clk_i       (clk),
        .rstn_i      (rstn),
        .cfg_i       (cfg),
        .in_valid_i  (in_valid),
        .in_beat_i   (in_beat),
        .in_ready_o  (in_ready),
        .out_valid_o (out_valid),
        .out_beat_o  (out_beat),
        .out_ready_i (out_ready),
        .spi_o       (spi),
        .spi_miso_i  (miso)
    );

    spi_echo_slave #(.FIRST_WORD(FIRST_WORD)) slave_i (
        .cpol_i (cfg.cpol),
        .cpha_i (cfg.cpha),
        .sclk_i (spi.sclk),
        .mosi_i (spi.mosi),
        .cs_n_i (spi.cs_n[cfg.addr]),
        .miso_o (miso)
    );

    // --------------------
    // Helpers
    // --------------------

    function automatic logic [SN-1:0] cs_for(input logic [AW-1:0] addr);
        logic [SN-1:0] v;
        v = '1;
        for (int i = 0; i < SN; i++) begin
            if (i == int'(addr)) begin
                v[i] = 1'b0;
            end
        end
        return v;
    endfunction

    task automatic report_value(input string what, input logic [31:0] expected,
                                input logic [31:0] actual);
        errors++;
        $display("FAILED %s: %s expected %0h actual %0h", test_name, what, expected, actual);
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR in %s: %s", test_name, msg);
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors == test_start_errors) begin
            $display("passed %s", test_name);
        end else begin
            tests_failed++;
            $display("FAILED %s: expected 0 errors actual %0d", test_name,
                     errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    task automatic send_word(input logic [W-1:0] data, input logic last);
        @(posedge clk);
        in_valid     <= 1'b1;
        in_beat.data <= data;
        in_beat.last <= last;
        @(negedge clk);
        while (!in_ready) @(negedge clk);
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    // Frame closed, outputs drained and gap over
    task automatic wait_idle();
        @(negedge clk);
        while (!(exp_q.size() == 0 && in_ready && !out_valid)) @(negedge clk);
    endtask

    // --------------------
    // Monitors
    // --------------------

    always @(negedge clk) begin : model
        stream_pkg::stream_beat_t beat;
        if (rstn) begin
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    exp_missing = 1'b1;
                end else begin
                    exp_missing = 1'b0;
                    exp_head    = exp_q.pop_front();
                end
            end
            if (in_valid && in_ready) begin
                beat.data = first_word ? FIRST_WORD : prev_data;
                beat.last = in_beat.last;
                exp_q.push_back(beat);
                prev_data  = in_beat.data;
                first_word = in_beat.last;
            end
        end
    end

    // Cycles since chip select went high, saturating
    assign cs_high = (spi.cs_n == '1);

    always_comb begin
        if (!cs_high) begin
            gap_age = '0;
        end else if (!cs_high_q) begin
            gap_age = 1;
        end else if (gap_age_q == '1) begin
            gap_age = '1;
        end else begin
            gap_age = gap_age_q + 1'b1;
        end
    end

    // Gap length of the frame that just closed
    assign gap_len = (cs_high && !cs_high_q) ? cfg.gap_time : gap_len_q;

    always_ff @(posedge clk) begin
        rstn_q <= rstn;
        if (!rstn) begin
            cs_high_q <= 1'b1;
            gap_age_q <= '1;
            gap_len_q <= '0;
        end else begin
            cs_high_q <= cs_high;
            gap_age_q <= gap_age;
            gap_len_q <= gap_len;
        end
    end

    // Random stalls on the output stream
    always @(posedge clk) begin : ready_stall
        logic [31:0] r;
        r = $random(seed);
        if (!rstn) begin
            out_ready <= 1'b0;
        end else begin
            out_ready <= r[0] | r[1];
        end
    end

    // --------------------
    // Assertions
    // --------------------

    reset_values: assert property (@(posedge clk) (rstn && !rstn_q) |->
        (in_ready && !out_valid && spi.cs_n == '1 && spi.sclk == cfg.cpol))
        else report_error("outputs not at their idle values after reset");

    no_extra_output: assert property (@(posedge clk) disable iff (!rstn)
        (out_valid && out_ready) |-> !exp_missing)
        else report_error("output beat with no matching input word");

    echo_data: assert property (@(posedge clk) disable iff (!rstn)
        (out_valid && out_ready && !exp_missing) |-> out_beat.data == exp_head.data)
        else report_value("echo data", 32'($sampled(exp_head.data)),
                          32'($sampled(out_beat.data)));

    echo_last: assert property (@(posedge clk) disable iff (!rstn)
        (out_valid && out_ready && !exp_missing) |-> out_beat.last == exp_head.last)
        else report_value("last flag", 32'($sampled(exp_head.last)),
                          32'($sampled(out_beat.last)));

    cs_decode: assert property (@(posedge clk) disable iff (!rstn)
        (spi.cs_n != '1) |-> spi.cs_n == cs_for(cfg.addr))
        else report_value("chip select", 32'($sampled(cs_for(cfg.addr))),
                          32'($sampled(spi.cs_n)));

    sclk_quiet: assert property (@(posedge clk) disable iff (!rstn)
        (cs_high && spi.sclk != $past(spi.sclk)) |-> spi.sclk == cfg.cpol)
        else report_error("SPI clock toggled with no chip select low");

    cs_follows_last: assert property (@(posedge clk) disable iff (!rstn)
        $rose(out_valid) |-> cs_high == out_beat.last)
        else report_value("chip select high after word", 32'($sampled(out_beat.last)),
                          32'($sampled(cs_high)));

    gap_hold: assert property (@(posedge clk) disable iff (!rstn)
        (gap_age != '0 && gap_age <= gap_len) |-> !in_ready)
        else report_error("input ready during the inter-frame gap");

    stall_hold: assert property (@(posedge clk) disable iff (!rstn)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_beat)))
        else report_error("output beat changed while stalled");

    no_accept_unread: assert property (@(posedge clk) disable iff (!rstn)
        out_valid |-> !in_ready)
        else report_error("input ready while an output beat is unread");

    // --------------------
    // Stimulus
    // --------------------

    initial begin
        seed              = 32'hb9d4_0784;
        in_valid          = 1'b0;
        in_beat           = '0;
        out_ready         = 1'b0;
        cfg               = '0;
        cfg.clk_div       = 4;
        cfg.gap_time      = 1;
        errors            = 0;
        test_start_errors = 0;
        tests_run         = 0;
        tests_failed      = 0;
        exp_head          = '0;
        exp_missing       = 1'b0;
        prev_data         = '0;
        first_word        = 1'b1;
        test_name         = "reset";

        wait (rstn);
        repeat (2) @(posedge clk);
        finish_test();

        for (int m = 0; m < 4; m++) begin
            test_name = $sformatf("mode%0d", m);
            for (int f = 0; f < FRAMES; f++) begin
                wait_idle();
                rnd = $random(seed);
                @(posedge clk);
                cfg.cpol     <= m[1];
                cfg.cpha     <= m[0];
                cfg.clk_div  <= 16'(4 + 2 * rnd[1:0]);
                cfg.gap_time <= 16'(1 + rnd[4:2]);
                cfg.addr     <= rnd[8 +: AW];
                nwords = 1 + int'(rnd[11:10]);
                for (int w = 0; w < nwords; w++) begin
                    // Draw away from the rising edge, where the stall process draws too
                    @(negedge clk);
                    rnd = $random(seed);
                    send_word(rnd[W-1:0], w == nwords - 1);
                end
            end
            wait_idle();
            finish_test();
        end

        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // Bound from word count, longest divider and gap
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog timeout, the run did not finish in time");
        $display("TESTS FAILED");
        $finish;
    end

endmodule
